//--- verif/memMapStimulus.txt
# op addr data anticSel gtiaSel hwData expected, all fields hex
# W write, R read, H hardware update, C CPU write with an update in the same cycle
R d400 00 0 00 0000 02
R d403 00 0 00 0000 a0
R d409 00 0 00 0000 f8
R d016 00 0 00 0000 5a
R d018 00 0 00 0000 7e
W 1234 a5 0 00 0000 00
R 1234 00 0 00 0000 a5
W ffff 81 0 00 0000 00
R ffff 00 0 00 0000 81
W d401 12 0 00 0000 00
R d401 00 0 00 0000 12
W d01a 94 0 00 0000 00
R d01a 00 0 00 0000 94
W d40b 55 0 00 0000 00
R d40b 00 0 00 0000 00
W d406 77 0 00 0000 00
R d406 00 0 00 0000 ff
R d108 00 0 00 0000 ff
H 0000 00 1 01 0044 00
R d402 00 0 00 0000 44
R d000 00 0 00 0000 44
H 0000 00 2 15 bc9a 00
R d403 00 0 00 0000 bc
R d014 00 0 00 0000 9a
H 0000 00 3 16 0071 00
R d40b 00 0 00 0000 71
R d01f 00 0 00 0000 71
H 0000 00 4 00 0023 00
R d40c 00 0 00 0000 23
H 0000 00 5 00 0045 00
R d40d 00 0 00 0000 45
H 0000 00 6 00 0080 00
R d40f 00 0 00 0000 80
C d402 11 2 00 6655 00
R d402 00 0 00 0000 11
R d403 00 0 00 0000 66
C d017 29 0 01 003e 00
R d017 00 0 00 0000 29
R d000 00 0 00 0000 3e

//--- verilog.f
+incdir+logic
logic/memMapPkg.sv
logic/cpuBusDecode.sv
logic/systemRam.sv
logic/anticRegs.sv
logic/gtiaRegs.sv
logic/memoryMap.sv
verif/memoryMapTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build the memory map testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module memoryMapTb -o memoryMapSim

./obj_dir/memoryMapSim | tee sim.log

if grep -qx "TB PASSED" sim.log; then
  echo "Simulation result: pass"
  exit 0
else
  echo "Simulation result: fail, see sim.log"
  exit 1
fi

//--- verif/memoryMapTb.sv
/* Memory map testbench */
`timescale 1ns/1ns
`include "memMap_consts.svh"
`default_nettype none

module memoryMapTb
  import memMapPkg::*;
();

  localparam int ClkPeriod = 20;
  localparam int RandPairs = 64;
  localparam int MaxOps = 256;

  logic               Fclk;
  logic               reset;
  cpuBusT             cpuBus;
  anticHwT            anticHw;
  gtiaHwT             gtiaHw;
  logic [`DATA_W-1:0] cpuRdData;
  anticViewT          anticView;
  gtiaViewT           gtiaView;

  // One record per stimulus line
  logic [7:0]         opCode [MaxOps];
  logic [15:0]        opAddr [MaxOps];
  logic [7:0]         opData [MaxOps];
  logic [2:0]         opAntic [MaxOps];
  logic [4:0]         opGtia [MaxOps];
  logic [15:0]        opHw [MaxOps];
  logic [7:0]         opExp [MaxOps];
  int                 numOps;
  logic               loaded;

  logic [7:0]         anticModel [`ANTIC_REGS];
  logic [7:0]         gtiaModel [`GTIA_REGS];
  logic [7:0]         ramModel [2**`ADDR_W];
  logic [15:0]        randAddr [RandPairs];

  int                 dataErrors;
  int                 anticErrors;
  int                 gtiaErrors;
  int                 otherErrors;
  integer             seed;

  memoryMap memoryMap_inst (
    .Fclk      (Fclk),
    .reset     (reset),
    .cpuBus    (cpuBus),
    .anticHw   (anticHw),
    .gtiaHw    (gtiaHw),
    .cpuRdData (cpuRdData),
    .anticView (anticView),
    .gtiaView  (gtiaView)
  );

  initial begin
    Fclk = 1'b0;
    forever #(ClkPeriod / 2) Fclk = ~Fclk;
  end

  task automatic loadStimulus();
    integer     fd;
    integer     got;
    integer     ch;
    logic [7:0] op;
    logic [15:0] addr;
    logic [7:0] data;
    logic [2:0] aSel;
    logic [4:0] gSel;
    logic [15:0] hwData;
    logic [7:0] expData;
    fd = $fopen("verif/memMapStimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file verif/memMapStimulus.txt");
      otherErrors++;
      return;
    end
    while (!$feof(fd)) begin
      got = $fscanf(fd, "%s", op);
      if (got != 1) break;
      if (op == "#") begin   // Skip the rest of a comment line
        ch = $fgetc(fd);
        while ((ch != 10) && (ch != -1)) ch = $fgetc(fd);
        continue;
      end
      got = $fscanf(fd, "%h %h %h %h %h %h", addr, data, aSel, gSel, hwData, expData);
      if ((got != 6) || !((op == "W") || (op == "R") || (op == "H") || (op == "C"))) begin
        $display("Malformed stimulus record after %0d good lines", numOps);
        otherErrors++;
        break;
      end
      if (numOps >= MaxOps) begin
        $display("Stimulus file holds more than %0d records", MaxOps);
        otherErrors++;
        break;
      end
      opCode[numOps] = op;
      opAddr[numOps] = addr;
      opData[numOps] = data;
      opAntic[numOps] = aSel;
      opGtia[numOps] = gSel;
      opHw[numOps] = hwData;
      opExp[numOps] = expData;
      numOps++;
    end
    $fclose(fd);
  endtask

  task automatic resetModels();
    for (int i = 0; i < `ANTIC_REGS; i++) anticModel[i] = 8'h00;
    for (int i = 0; i < `GTIA_REGS; i++) gtiaModel[i] = 8'h00;
    anticModel[`OFS_DMACTL] = `RST_DMACTL;
    anticModel[`OFS_DLISTL] = `RST_DLISTL;
    anticModel[`OFS_DLISTH] = `RST_DLISTH;
    anticModel[`OFS_CHBASE] = `RST_CHBASE;
    gtiaModel[`OFS_COLPF0] = `RST_COLPF0;
    gtiaModel[`OFS_COLPF1] = `RST_COLPF1;
    gtiaModel[`OFS_COLPF2] = `RST_COLPF2;
  endtask

  task automatic driveIdle();
    cpuBus = '0;
    anticHw = '0;
    gtiaHw = '0;
  endtask

  task automatic driveOp(input int i);
    logic isHw;
    isHw = (opCode[i] == "H") || (opCode[i] == "C");
    cpuBus.addr = opAddr[i];
    cpuBus.wrData = opData[i];
    cpuBus.writeEn = (opCode[i] == "W") || (opCode[i] == "C");
    anticHw.sel = isHw ? anticHwSelT'(opAntic[i]) : anticSelNone;
    // Fields the select code does not pick carry the inverted data
    anticHw.dlist = ~opHw[i];
    anticHw.vcount = ~opHw[i][7:0];
    anticHw.penH = ~opHw[i][7:0];
    anticHw.penV = ~opHw[i][7:0];
    anticHw.nmiSt = ~opHw[i][7:0];
    case (opAntic[i])
      3'd1, 3'd2: anticHw.dlist = opHw[i];
      3'd3: anticHw.vcount = opHw[i][7:0];
      3'd4: anticHw.penH = opHw[i][7:0];
      3'd5: anticHw.penV = opHw[i][7:0];
      3'd6: anticHw.nmiSt = opHw[i][7:0];
      default: ;
    endcase
    gtiaHw.sel = isHw ? opGtia[i] : 5'd0;
    gtiaHw.data = opHw[i][7:0];
  endtask

  task automatic applyToModels(input int i);
    logic       isHw;
    logic       isCpu;
    logic [3:0] aOfs;
    logic [4:0] gOfs;
    isHw = (opCode[i] == "H") || (opCode[i] == "C");
    isCpu = (opCode[i] == "W") || (opCode[i] == "C");
    aOfs = opAddr[i][3:0];
    gOfs = opAddr[i][4:0];
    if (isHw) begin
      case (opAntic[i])
        3'd1: anticModel[`OFS_DLISTL] = opHw[i][7:0];
        3'd2: begin
          anticModel[`OFS_DLISTL] = opHw[i][7:0];
          anticModel[`OFS_DLISTH] = opHw[i][15:8];
        end
        3'd3: anticModel[`OFS_VCOUNT] = opHw[i][7:0];
        3'd4: anticModel[`OFS_PENH] = opHw[i][7:0];
        3'd5: anticModel[`OFS_PENV] = opHw[i][7:0];
        3'd6: anticModel[`OFS_NMIST] = opHw[i][7:0];
        default: ;
      endcase
      if ((opGtia[i] >= 5'd1) && (opGtia[i] <= 5'd21)) begin
        gtiaModel[opGtia[i] - 5'd1] = opHw[i][7:0];
      end else if (opGtia[i] == 5'd22) begin
        gtiaModel[`OFS_CONSOL] = opHw[i][7:0];
      end
    end
    // CPU write goes in last so it overrides an update of the same byte
    if (isCpu && ((opAddr[i] & 16'hFFF0) == `ANTIC_BASE) && (aOfs != 4'h6) && (aOfs != 4'h8)
        && (aOfs != `OFS_VCOUNT) && (aOfs != `OFS_PENH) && (aOfs != `OFS_PENV)) begin
      anticModel[aOfs] = opData[i];
    end
    if (isCpu && ((opAddr[i] & 16'hFFE0) == `GTIA_BASE)) begin
      gtiaModel[gOfs] = opData[i];
    end
  endtask

  function automatic anticViewT expectedAnticView();
    anticViewT v;
    v.dmaCtl = anticModel[`OFS_DMACTL];
    v.chaCtl = anticModel[`OFS_CHACTL];
    v.dlist = {anticModel[`OFS_DLISTH], anticModel[`OFS_DLISTL]};
    v.hScrol = anticModel[`OFS_HSCROL];
    v.vScrol = anticModel[`OFS_VSCROL];
    v.pmBase = anticModel[`OFS_PMBASE];
    v.chBase = anticModel[`OFS_CHBASE];
    v.wSync = anticModel[`OFS_WSYNC];
    v.nmiEn = anticModel[`OFS_NMIEN];
    return v;
  endfunction

  function automatic gtiaViewT expectedGtiaView();
    gtiaViewT v;
    v.colPm3 = gtiaModel[`OFS_COLPM3];
    v.colPf0 = gtiaModel[`OFS_COLPF0];
    v.colPf1 = gtiaModel[`OFS_COLPF1];
    v.colPf2 = gtiaModel[`OFS_COLPF2];
    v.colPf3 = gtiaModel[`OFS_COLPF3];
    v.colBk = gtiaModel[`OFS_COLBK];
    v.prior = gtiaModel[`OFS_PRIOR];
    v.vDelay = gtiaModel[`OFS_VDELAY];
    v.graCtl = gtiaModel[`OFS_GRACTL];
    v.hitClr = gtiaModel[`OFS_HITCLR];
    return v;
  endfunction

  task automatic checkData(input string name, input logic [15:0] addr,
                           input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s addr %h got %h expected %h", name, addr, got, exp);
      dataErrors++;
    end
  endtask

  task automatic checkAnticView(input anticViewT got, input anticViewT exp);
    if (got !== exp) begin
      $display("FAIL anticView got %h expected %h", got, exp);
      anticErrors++;
    end
  endtask

  task automatic checkGtiaView(input gtiaViewT got, input gtiaViewT exp);
    if (got !== exp) begin
      $display("FAIL gtiaView got %h expected %h", got, exp);
      gtiaErrors++;
    end
  endtask

  // Entered and left on a falling edge
  task automatic runOp(input int i);
    driveOp(i);
    applyToModels(i);
    @(posedge Fclk);
    @(negedge Fclk);
    if (opCode[i] == "R") checkData("cpuRdData", opAddr[i], cpuRdData, opExp[i]);
    checkAnticView(anticView, expectedAnticView());
    checkGtiaView(gtiaView, expectedGtiaView());
  endtask

  task automatic ramRandomTest();
    logic [31:0] r;
    logic [15:0] a;
    logic [7:0]  d;
    anticHw = '0;
    gtiaHw = '0;
    for (int k = 0; k < RandPairs; k++) begin
      r = $random(seed);
      a = r[15:0];
      d = r[23:16];
      if (a[15:12] == `IO_PAGE) a[12] = 1'b0;   // Move out of the I/O page
      randAddr[k] = a;
      ramModel[a] = d;
      cpuBus = '{addr: a, wrData: d, writeEn: 1'b1};
      @(posedge Fclk);
      @(negedge Fclk);
    end
    for (int k = 0; k < RandPairs; k++) begin
      cpuBus = '{addr: randAddr[k], wrData: 8'h00, writeEn: 1'b0};
      @(posedge Fclk);
      @(negedge Fclk);
      checkData("cpuRdData", randAddr[k], cpuRdData, ramModel[randAddr[k]]);
    end
  endtask

  initial begin
    seed = 32'hde5adea6;
    numOps = 0;
    loaded = 1'b0;
    dataErrors = 0;
    anticErrors = 0;
    gtiaErrors = 0;
    otherErrors = 0;
    reset = 1'b1;
    driveIdle();
    resetModels();
    loadStimulus();
    loaded = 1'b1;
    repeat (3) @(posedge Fclk);
    @(negedge Fclk);
    reset = 1'b0;
    checkData("cpuRdData", 16'h0000, cpuRdData, 8'h00);   // Read path cleared by reset
    checkAnticView(anticView, expectedAnticView());   // Reset contents
    checkGtiaView(gtiaView, expectedGtiaView());
    for (int i = 0; i < numOps; i++) runOp(i);
    ramRandomTest();
    driveIdle();
    $display("Errors: data %0d, ANTIC view %0d, GTIA view %0d, other %0d",
             dataErrors, anticErrors, gtiaErrors, otherErrors);
    if ((dataErrors + anticErrors + gtiaErrors + otherErrors) == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Budget of one cycle per operation plus slack for reset and drain
  initial begin
    wait (loaded === 1'b1);
    #((numOps + 2 * RandPairs + 20) * ClkPeriod);
    $display("Simulation timed out before all operations completed");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/memoryMap.sv
/* Memory map top level */
`timescale 1ns/1ns
`include "memMap_consts.svh"
`default_nettype none

module memoryMap
  import memMapPkg::*;
(
  input  wire                 Fclk,
  input  wire                 reset,
  input  wire cpuBusT         cpuBus,
  input  wire anticHwT        anticHw,
  input  wire gtiaHwT         gtiaHw,
  output logic [`DATA_W-1:0]  cpuRdData,
  output anticViewT           anticView,
  output gtiaViewT            gtiaView
);

  logic                           ramWrite;
  logic                           anticWrite;
  logic                           gtiaWrite;
  logic [$clog2(`ANTIC_REGS)-1:0] anticOffset;
  logic [$clog2(`GTIA_REGS)-1:0]  gtiaOffset;
  logic [`DATA_W-1:0]             ramRdData;
  logic [`DATA_W-1:0]             anticRdData;
  logic [`DATA_W-1:0]             gtiaRdData;

  cpuBusDecode decode_inst (
    .Fclk        (Fclk),
    .reset       (reset),
    .cpuBus      (cpuBus),
    .ramRdData   (ramRdData),
    .anticRdData (anticRdData),
    .gtiaRdData  (gtiaRdData),
    .ramWrite    (ramWrite),
    .anticWrite  (anticWrite),
    .anticOffset (anticOffset),
    .gtiaWrite   (gtiaWrite),
    .gtiaOffset  (gtiaOffset),
    .cpuRdData   (cpuRdData)
  );

  systemRam ram_inst (
    .Fclk   (Fclk),
    .addr   (cpuBus.addr),
    .wrData (cpuBus.wrData),
    .write  (ramWrite),
    .rdData (ramRdData)
  );

  anticRegs antic_inst (
    .Fclk      (Fclk),
    .reset     (reset),
    .cpuWrite  (anticWrite),
    .cpuOffset (anticOffset),
    .cpuData   (cpuBus.wrData),
    .hw        (anticHw),
    .rdData    (anticRdData),
    .view      (anticView)
  );

  gtiaRegs gtia_inst (
    .Fclk      (Fclk),
    .reset     (reset),
    .cpuWrite  (gtiaWrite),
    .cpuOffset (gtiaOffset),
    .cpuData   (cpuBus.wrData),
    .hw        (gtiaHw),
    .rdData    (gtiaRdData),
    .view      (gtiaView)
  );

endmodule

`default_nettype wire

//--- logic/gtiaRegs.sv
/* GTIA register file */
`timescale 1ns/1ns
`include "memMap_consts.svh"
`default_nettype none

module gtiaRegs
  import memMapPkg::*;
(
  input  wire                            Fclk,
  input  wire                            reset,
  input  wire                            cpuWrite,
  input  wire [$clog2(`GTIA_REGS)-1:0]   cpuOffset,
  input  wire [`DATA_W-1:0]              cpuData,
  input  wire gtiaHwT                    hw,
  output logic [`DATA_W-1:0]             rdData,
  output gtiaViewT                       view
);

  localparam int OfsW = $clog2(`GTIA_REGS);

  logic [`DATA_W-1:0] regFile [`GTIA_REGS];
  logic               hwValid;
  logic [OfsW-1:0]    hwOfs;

  function automatic logic [`DATA_W-1:0] resetValue(input logic [OfsW-1:0] ofs);
    case (ofs)
      `OFS_COLPF0: return `RST_COLPF0;
      `OFS_COLPF1: return `RST_COLPF1;
      `OFS_COLPF2: return `RST_COLPF2;
      default:     return '0;
    endcase
  endfunction

  // Collision/trigger codes to register offset
  always_comb begin
    hwValid = 1'b0;
    hwOfs = '0;
    if ((hw.sel != '0) && (hw.sel <= `GTIA_HW_LAST_DIRECT)) begin
      hwValid = 1'b1;
      hwOfs = hw.sel - 5'd1;   // Code 1 is HPOSP0/M0PF at offset 0
    end else if (hw.sel == `GTIA_HW_CONSOL) begin
      hwValid = 1'b1;
      hwOfs = `OFS_CONSOL;
    end
  end

  always_ff @(posedge Fclk) begin
    for (int i = 0; i < `GTIA_REGS; i++) begin
      if (reset) begin
        regFile[i] <= resetValue(OfsW'(i));
      end else if (cpuWrite && (cpuOffset == OfsW'(i))) begin
        regFile[i] <= cpuData;   // CPU has priority
      end else if (hwValid && (hwOfs == OfsW'(i))) begin
        regFile[i] <= hw.data;
      end
    end
  end

  assign rdData = regFile[cpuOffset];

  // Colour and control block straight from the flops
  assign view = '{
    colPm3: regFile[`OFS_COLPM3],
    colPf0: regFile[`OFS_COLPF0],
    colPf1: regFile[`OFS_COLPF1],
    colPf2: regFile[`OFS_COLPF2],
    colPf3: regFile[`OFS_COLPF3],
    colBk:  regFile[`OFS_COLBK],
    prior:  regFile[`OFS_PRIOR],
    vDelay: regFile[`OFS_VDELAY],
    graCtl: regFile[`OFS_GRACTL],
    hitClr: regFile[`OFS_HITCLR]
  };

endmodule

`default_nettype wire

//--- logic/anticRegs.sv
/* ANTIC register file */
`timescale 1ns/1ns
`include "memMap_consts.svh"
`default_nettype none

module anticRegs
  import memMapPkg::*;
(
  input  wire                             Fclk,
  input  wire                             reset,
  input  wire                             cpuWrite,
  input  wire [$clog2(`ANTIC_REGS)-1:0]   cpuOffset,
  input  wire [`DATA_W-1:0]               cpuData,
  input  wire anticHwT                    hw,
  output logic [`DATA_W-1:0]              rdData,
  output anticViewT                       view
);

  localparam int OfsW = $clog2(`ANTIC_REGS);

  logic [`DATA_W-1:0]    regFile [`ANTIC_REGS];
  logic [`DATA_W-1:0]    hwValue [`ANTIC_REGS];
  logic [`ANTIC_REGS-1:0] hwLoad;

  function automatic logic [`DATA_W-1:0] resetValue(input logic [OfsW-1:0] ofs);
    case (ofs)
      `OFS_DMACTL: return `RST_DMACTL;
      `OFS_DLISTL: return `RST_DLISTL;
      `OFS_DLISTH: return `RST_DLISTH;
      `OFS_CHBASE: return `RST_CHBASE;
      default:     return '0;
    endcase
  endfunction

  function automatic logic isReadOnly(input logic [OfsW-1:0] ofs);
    return (ofs == `OFS_VCOUNT) || (ofs == `OFS_PENH) || (ofs == `OFS_PENV);
  endfunction

  // Decode the hardware select into per-register loads
  always_comb begin
    hwLoad = '0;
    for (int i = 0; i < `ANTIC_REGS; i++) begin
      hwValue[i] = '0;
    end
    case (hw.sel)
      anticSelDlistL: begin
        hwLoad[`OFS_DLISTL] = 1'b1;
        hwValue[`OFS_DLISTL] = hw.dlist[7:0];
      end
      anticSelDlist: begin
        hwLoad[`OFS_DLISTL] = 1'b1;
        hwLoad[`OFS_DLISTH] = 1'b1;
        hwValue[`OFS_DLISTL] = hw.dlist[7:0];
        hwValue[`OFS_DLISTH] = hw.dlist[15:8];
      end
      anticSelVcount: begin
        hwLoad[`OFS_VCOUNT] = 1'b1;
        hwValue[`OFS_VCOUNT] = hw.vcount;
      end
      anticSelPenH: begin
        hwLoad[`OFS_PENH] = 1'b1;
        hwValue[`OFS_PENH] = hw.penH;
      end
      anticSelPenV: begin
        hwLoad[`OFS_PENV] = 1'b1;
        hwValue[`OFS_PENV] = hw.penV;
      end
      anticSelNmiSt: begin
        hwLoad[`OFS_NMIST] = 1'b1;
        hwValue[`OFS_NMIST] = hw.nmiSt;
      end
      default: ;   // Idle
    endcase
  end

  // CPU write beats a hardware load on the same byte
  always_ff @(posedge Fclk) begin
    for (int i = 0; i < `ANTIC_REGS; i++) begin
      if (reset) begin
        regFile[i] <= resetValue(OfsW'(i));
      end else if (cpuWrite && (cpuOffset == OfsW'(i)) && !isReadOnly(OfsW'(i))) begin
        regFile[i] <= cpuData;
      end else if (hwLoad[i]) begin
        regFile[i] <= hwValue[i];
      end
    end
  end

  assign rdData = regFile[cpuOffset];

  assign view = '{
    dmaCtl: regFile[`OFS_DMACTL],
    chaCtl: regFile[`OFS_CHACTL],
    dlist:  {regFile[`OFS_DLISTH], regFile[`OFS_DLISTL]},
    hScrol: regFile[`OFS_HSCROL],
    vScrol: regFile[`OFS_VSCROL],
    pmBase: regFile[`OFS_PMBASE],
    chBase: regFile[`OFS_CHBASE],
    wSync:  regFile[`OFS_WSYNC],
    nmiEn:  regFile[`OFS_NMIEN]
  };

endmodule

`default_nettype wire

//--- logic/systemRam.sv
/* System RAM, 64 KiB */
`timescale 1ns/1ns
`include "memMap_consts.svh"
`default_nettype none

module systemRam (
  input  wire                 Fclk,
  input  wire [`ADDR_W-1:0]   addr,
  input  wire [`DATA_W-1:0]   wrData,
  input  wire                 write,
  output logic [`DATA_W-1:0]  rdData
);

  logic [`DATA_W-1:0] mem [2**`ADDR_W];

  // Single port, read sees the old word on a same-address write
  always_ff @(posedge Fclk) begin
    if (write) begin
      mem[addr] <= wrData;
    end
    rdData <= mem[addr];   // Registered read
  end

endmodule

`default_nettype wire

//--- logic/cpuBusDecode.sv
/* CPU address decode and read return */
`timescale 1ns/1ns
`include "memMap_consts.svh"
`default_nettype none

module cpuBusDecode
  import memMapPkg::*;
(
  input  wire                                 Fclk,
  input  wire                                 reset,
  input  wire cpuBusT                         cpuBus,
  input  wire [`DATA_W-1:0]                   ramRdData,
  input  wire [`DATA_W-1:0]                   anticRdData,
  input  wire [`DATA_W-1:0]                   gtiaRdData,
  output logic                                ramWrite,
  output logic                                anticWrite,
  output logic [$clog2(`ANTIC_REGS)-1:0]      anticOffset,
  output logic                                gtiaWrite,
  output logic [$clog2(`GTIA_REGS)-1:0]       gtiaOffset,
  output logic [`DATA_W-1:0]                  cpuRdData
);

  localparam int AnticOfsW = $clog2(`ANTIC_REGS);
  localparam int GtiaOfsW = $clog2(`GTIA_REGS);
  localparam logic [`ADDR_W-1:0] anticBase = `ANTIC_BASE;
  localparam logic [`ADDR_W-1:0] gtiaBase = `GTIA_BASE;

  logic               inIoPage;
  logic               hitAntic;
  logic               hitGtia;
  logic               ramSelQ;    // Last access went to RAM
  logic [`DATA_W-1:0] regDataQ;   // Captured register or unmapped value

  assign inIoPage = cpuBus.addr[`ADDR_W-1 -: 4] == `IO_PAGE;
  assign anticOffset = cpuBus.addr[AnticOfsW-1:0];
  assign gtiaOffset = cpuBus.addr[GtiaOfsW-1:0];

  // ANTIC window minus its two empty slots
  assign hitAntic = (cpuBus.addr[`ADDR_W-1:AnticOfsW] == anticBase[`ADDR_W-1:AnticOfsW])
                    && (anticOffset != `OFS_ANTIC_HOLE0)
                    && (anticOffset != `OFS_ANTIC_HOLE1);
  assign hitGtia = cpuBus.addr[`ADDR_W-1:GtiaOfsW] == gtiaBase[`ADDR_W-1:GtiaOfsW];

  assign ramWrite = cpuBus.writeEn && !inIoPage;
  assign anticWrite = cpuBus.writeEn && hitAntic;
  assign gtiaWrite = cpuBus.writeEn && hitGtia;   // Other I/O writes fall on the floor

  // Register data is sampled here so it lines up with the RAM output register
  always_ff @(posedge Fclk) begin
    if (reset) begin
      ramSelQ <= 1'b0;
      regDataQ <= '0;
    end else begin
      ramSelQ <= !inIoPage;
      if (hitAntic) begin
        regDataQ <= anticRdData;
      end else if (hitGtia) begin
        regDataQ <= gtiaRdData;
      end else begin
        regDataQ <= `UNMAPPED_READ;
      end
    end
  end

  assign cpuRdData = ramSelQ ? ramRdData : regDataQ;

endmodule

`default_nettype wire

//--- logic/memMapPkg.sv
/* Memory map types */
`include "memMap_consts.svh"
`default_nettype none

package memMapPkg;

  // CPU request as seen on the address/data pins
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] wrData;
    logic               writeEn;
  } cpuBusT;

  typedef enum logic [2:0] {
    anticSelNone   = 3'd0,
    anticSelDlistL = 3'd1,   // Low byte only
    anticSelDlist  = 3'd2,   // Both bytes
    anticSelVcount = 3'd3,
    anticSelPenH   = 3'd4,
    anticSelPenV   = 3'd5,
    anticSelNmiSt  = 3'd6
  } anticHwSelT;

  typedef struct packed {
    anticHwSelT         sel;
    logic [15:0]        dlist;
    logic [`DATA_W-1:0] vcount;
    logic [`DATA_W-1:0] penH;
    logic [`DATA_W-1:0] penV;
    logic [`DATA_W-1:0] nmiSt;
  } anticHwT;

  typedef struct packed {
    logic [$clog2(`GTIA_REGS)-1:0] sel;   // 0 idle, 1..21 direct, 22 CONSOL
    logic [`DATA_W-1:0]            data;
  } gtiaHwT;

  typedef struct packed {
    logic [`DATA_W-1:0] dmaCtl;
    logic [`DATA_W-1:0] chaCtl;
    logic [15:0]        dlist;
    logic [`DATA_W-1:0] hScrol;
    logic [`DATA_W-1:0] vScrol;
    logic [`DATA_W-1:0] pmBase;
    logic [`DATA_W-1:0] chBase;
    logic [`DATA_W-1:0] wSync;
    logic [`DATA_W-1:0] nmiEn;
  } anticViewT;

  typedef struct packed {
    logic [`DATA_W-1:0] colPm3;
    logic [`DATA_W-1:0] colPf0;
    logic [`DATA_W-1:0] colPf1;
    logic [`DATA_W-1:0] colPf2;
    logic [`DATA_W-1:0] colPf3;
    logic [`DATA_W-1:0] colBk;
    logic [`DATA_W-1:0] prior;
    logic [`DATA_W-1:0] vDelay;
    logic [`DATA_W-1:0] graCtl;
    logic [`DATA_W-1:0] hitClr;
  } gtiaViewT;

endpackage

`default_nettype wire

//--- logic/memMap_consts.svh
/* Memory map constants */
`ifndef MEMMAP_CONSTS_SVH
`define MEMMAP_CONSTS_SVH

`define DATA_W        8
`define ADDR_W        16
`define IO_PAGE       4'hD      // Top nibble of the I/O page
`define ANTIC_BASE    16'hD400
`define GTIA_BASE     16'hD000
`define ANTIC_REGS    16
`define GTIA_REGS     32
`define UNMAPPED_READ 8'hFF

// ANTIC offsets
`define OFS_DMACTL      4'h0
`define OFS_CHACTL      4'h1
`define OFS_DLISTL      4'h2
`define OFS_DLISTH      4'h3
`define OFS_HSCROL      4'h4
`define OFS_VSCROL      4'h5
`define OFS_ANTIC_HOLE0 4'h6    // No register here
`define OFS_PMBASE      4'h7
`define OFS_ANTIC_HOLE1 4'h8    // No register here
`define OFS_CHBASE      4'h9
`define OFS_WSYNC       4'hA
`define OFS_VCOUNT      4'hB    // Read only
`define OFS_PENH        4'hC    // Read only
`define OFS_PENV        4'hD    // Read only
`define OFS_NMIEN       4'hE
`define OFS_NMIST       4'hF

// GTIA offsets of the colour/control block
`define OFS_COLPM3 5'h15
`define OFS_COLPF0 5'h16
`define OFS_COLPF1 5'h17
`define OFS_COLPF2 5'h18
`define OFS_COLPF3 5'h19
`define OFS_COLBK  5'h1A
`define OFS_PRIOR  5'h1B
`define OFS_VDELAY 5'h1C
`define OFS_GRACTL 5'h1D
`define OFS_HITCLR 5'h1E
`define OFS_CONSOL 5'h1F

// GTIA hardware codes 1..21 map straight onto offsets 0..20
`define GTIA_HW_LAST_DIRECT 5'd21
`define GTIA_HW_CONSOL      5'd22

`define RST_DMACTL 8'h02
`define RST_DLISTL 8'h03
`define RST_DLISTH 8'hA0
`define RST_CHBASE 8'hF8
`define RST_COLPF0 8'h5A
`define RST_COLPF1 8'h38
`define RST_COLPF2 8'h7E

`endif
